// ==== logic/board_params.svh ====
// Bus widths, RTC divider and fan PWM constants, register addresses

`ifndef BOARD_PARAMS_SVH
`define BOARD_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// Register bus
////////////////////////////////////////////////////////////////////////////

`define BOARD_REG_ADDR_W   4
`define BOARD_REG_DATA_W   32

// Word addresses in the register block
`define BOARD_ADDR_LED     0
`define BOARD_ADDR_CTRL    1

////////////////////////////////////////////////////////////////////////////
// Board peripherals
////////////////////////////////////////////////////////////////////////////

`define BOARD_LED_W        8
`define BOARD_FAN_LEVEL_W  4
// Fan PWM period in soc_clk cycles
`define BOARD_FAN_STEPS    15
// Half period of the RTC square wave, 50 MHz down to 1 MHz
`define BOARD_RTC_HALF_DIV 25
`define BOARD_RTC_CNT_W    16
`define BOARD_SPI_CS_W     2
`define BOARD_QSPI_W       4

`endif

// ==== logic/board_pkg.sv ====
// Package with register word, field and layout types for the board glue

`include "board_params.svh"

package board_pkg;

  typedef logic [`BOARD_REG_ADDR_W-1:0]  reg_addr_t;
  typedef logic [`BOARD_REG_DATA_W-1:0]  reg_data_t;
  typedef logic [`BOARD_FAN_LEVEL_W-1:0] fan_level_t;
  typedef logic [1:0]                    boot_mode_t;

  ////////////////////////////////////////////////////////////////////////////
  // Register layouts
  ////////////////////////////////////////////////////////////////////////////

  // LED register, one bit per board LED
  typedef struct packed {
    logic [`BOARD_REG_DATA_W-`BOARD_LED_W-1:0] rsvd;
    logic [`BOARD_LED_W-1:0]                   leds;
  } led_word_t;

  // Control register, fan and boot-mode overrides
  typedef struct packed {
    logic [`BOARD_REG_DATA_W-9:0] rsvd;
    logic                         boot_sel;
    boot_mode_t                   boot_mode;
    logic                         fan_override;
    fan_level_t                   fan_level;
  } ctrl_word_t;

  // Same bus word, seen in the layout the address selects
  typedef union packed {
    led_word_t  led;
    ctrl_word_t ctrl;
  } cfg_word_u;

endpackage

// ==== logic/rtc_divider.sv ====
// RTC divider: slow square wave derived from soc_clk

`include "board_params.svh"

module rtc_divider (
  input  logic soc_clk,
  input  logic rst_n,
  output logic rtc_clk_o
);

  localparam logic [`BOARD_RTC_CNT_W-1:0] LastCnt =
    `BOARD_RTC_CNT_W'(`BOARD_RTC_HALF_DIV - 1);

  logic [`BOARD_RTC_CNT_W-1:0] cnt_q;
  logic                        rtc_q;
  logic                        wrap;

  // Counter reaches the end of a half period
  assign wrap = (cnt_q == LastCnt);

  always_ff @(posedge soc_clk, negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
      rtc_q <= 1'b0;
    end else if (wrap) begin
      cnt_q <= '0;
      rtc_q <= ~rtc_q;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign rtc_clk_o = rtc_q;

endmodule

// ==== logic/board_cfg_regs.sv ====
// Board configuration registers: LEDs, fan level and override, boot-mode override

`include "board_params.svh"

module board_cfg_regs (
  input  logic                    soc_clk,
  input  logic                    rst_n,
  input  logic                    reg_req_i,
  input  logic                    reg_we_i,
  input  board_pkg::reg_addr_t    reg_addr_i,
  input  board_pkg::reg_data_t    reg_wdata_i,
  input  board_pkg::fan_level_t   fan_sw_i,
  input  board_pkg::boot_mode_t   boot_mode_i,
  output board_pkg::reg_data_t    reg_rdata_o,
  output logic                    reg_rvalid_o,
  output logic [`BOARD_LED_W-1:0] led_o,
  output board_pkg::fan_level_t   fan_level_o,
  output board_pkg::boot_mode_t   boot_mode_o
);

  localparam board_pkg::reg_addr_t AddrLed  = board_pkg::reg_addr_t'(`BOARD_ADDR_LED);
  localparam board_pkg::reg_addr_t AddrCtrl = board_pkg::reg_addr_t'(`BOARD_ADDR_CTRL);

  board_pkg::cfg_word_u  wr_word;
  board_pkg::cfg_word_u  rd_word;
  logic                  led_we;
  logic                  ctrl_we;
  logic                  rd_req;

  logic [`BOARD_LED_W-1:0] led_q;
  board_pkg::ctrl_word_t   ctrl_q;
  board_pkg::reg_data_t    rdata_q;
  logic                    rvalid_q;

  ////////////////////////////////////////////////////////////////////////////
  // Bus decode
  ////////////////////////////////////////////////////////////////////////////

  assign wr_word = reg_wdata_i;
  assign led_we  = reg_req_i & reg_we_i & (reg_addr_i == AddrLed);
  assign ctrl_we = reg_req_i & reg_we_i & (reg_addr_i == AddrCtrl);
  assign rd_req  = reg_req_i & ~reg_we_i;

  // Read mux, unmapped addresses return zero
  always_comb begin
    rd_word = '0;
    case (reg_addr_i)
      AddrLed:  rd_word.led.leds = led_q;
      AddrCtrl: rd_word.ctrl     = ctrl_q;
      default:  ;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge soc_clk, negedge rst_n) begin
    if (!rst_n) begin
      led_q    <= '0;
      ctrl_q   <= '0;
      rdata_q  <= '0;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= rd_req;
      if (rd_req) begin
        rdata_q <= rd_word;
      end
      if (led_we) begin
        led_q <= wr_word.led.leds;
      end
      if (ctrl_we) begin
        ctrl_q.fan_level    <= wr_word.ctrl.fan_level;
        ctrl_q.fan_override <= wr_word.ctrl.fan_override;
        ctrl_q.boot_mode    <= wr_word.ctrl.boot_mode;
        ctrl_q.boot_sel     <= wr_word.ctrl.boot_sel;
      end else if (!ctrl_q.fan_override) begin
        // No override, level tracks the board switches
        ctrl_q.fan_level <= fan_sw_i;
      end
    end
  end

  assign reg_rdata_o  = rdata_q;
  assign reg_rvalid_o = rvalid_q;
  assign led_o        = led_q;
  assign fan_level_o  = ctrl_q.fan_level;
  assign boot_mode_o  = ctrl_q.boot_sel ? ctrl_q.boot_mode : boot_mode_i;

endmodule

// ==== logic/fan_pwm.sv ====
// Fan PWM generator: level in, duty-cycled fan drive out

`include "board_params.svh"

module fan_pwm (
  input  logic                  soc_clk,
  input  logic                  rst_n,
  input  board_pkg::fan_level_t level_i,
  output logic                  fan_pwm_o
);

  localparam board_pkg::fan_level_t LastStep =
    board_pkg::fan_level_t'(`BOARD_FAN_STEPS - 1);

  board_pkg::fan_level_t step_q;

  ////////////////////////////////////////////////////////////////////////////
  // Period counter
  ////////////////////////////////////////////////////////////////////////////

  // Runs 0 .. LastStep, one full period per fan cycle
  always_ff @(posedge soc_clk, negedge rst_n) begin
    if (!rst_n) begin
      step_q <= '0;
    end else if (step_q == LastStep) begin
      step_q <= '0;
    end else begin
      step_q <= step_q + 1'b1;
    end
  end

  // High for exactly level_i steps of each period
  // Level 0 never drives, level 15 always does
  assign fan_pwm_o = (step_q < level_i);

endmodule

// ==== logic/spi_pin_mux.sv ====
// SPI pin mux: host SPI to SD card in SPI mode and quad-SPI flash, return data merge

`include "board_params.svh"

module spi_pin_mux (
  // Host SPI master
  input  logic                      spih_sck_i,
  input  logic                      spih_sck_en_i,
  input  logic [`BOARD_SPI_CS_W-1:0] spih_csb_i,
  input  logic [`BOARD_SPI_CS_W-1:0] spih_csb_en_i,
  input  logic [`BOARD_QSPI_W-1:0]   spih_sd_i,
  input  logic [`BOARD_QSPI_W-1:0]   spih_sd_en_i,
  output logic [`BOARD_QSPI_W-1:0]   spih_sd_o_to_host,
  // SD card, SPI mode
  output logic                      sd_sclk_o,
  output logic                      sd_cs_o,
  output logic                      sd_cmd_o,
  input  logic                      sd_dat0_i,
  // Quad-SPI flash
  output logic                      qspi_sck_o,
  output logic                      qspi_sck_oe_o,
  output logic                      qspi_csb_o,
  output logic                      qspi_csb_oe_o,
  output logic [`BOARD_QSPI_W-1:0]   qspi_sd_o,
  output logic [`BOARD_QSPI_W-1:0]   qspi_sd_oe_o,
  input  logic [`BOARD_QSPI_W-1:0]   qspi_sd_i
);

  logic [`BOARD_QSPI_W-1:0] sd_src;

  ////////////////////////////////////////////////////////////////////////////
  // SD card side
  ////////////////////////////////////////////////////////////////////////////

  // Idle lines park high
  assign sd_sclk_o = spih_sck_en_i    ? spih_sck_i    : 1'b1;
  // DAT3 doubles as chip select in SPI mode
  assign sd_cs_o   = spih_csb_en_i[0] ? spih_csb_i[0] : 1'b1;
  // CMD carries MOSI
  assign sd_cmd_o  = spih_sd_en_i[0]  ? spih_sd_i[0]  : 1'b1;

  // MISO from DAT0 lands on host lane 1
  always_comb begin
    sd_src    = '0;
    sd_src[1] = sd_dat0_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Flash side
  ////////////////////////////////////////////////////////////////////////////

  assign qspi_sck_o    = spih_sck_i;
  assign qspi_sck_oe_o = spih_sck_en_i;
  assign qspi_csb_o    = spih_csb_i[1];
  assign qspi_csb_oe_o = spih_csb_en_i[1];
  assign qspi_sd_o     = spih_sd_i;
  assign qspi_sd_oe_o  = spih_sd_en_i;

  // Return data by active-low chip select
  assign spih_sd_o_to_host = ({`BOARD_QSPI_W{~spih_csb_i[0]}} & sd_src)
                           | ({`BOARD_QSPI_W{~spih_csb_i[1]}} & qspi_sd_i);

endmodule

// ==== logic/board_io_top.sv ====
// Board glue top level: RTC divider, config registers, fan PWM and SPI pin mux

`include "board_params.svh"

module board_io_top (
  input  logic                       soc_clk,
  input  logic                       rst_n,
  // Register bus
  input  logic                       reg_req_i,
  input  logic                       reg_we_i,
  input  board_pkg::reg_addr_t       reg_addr_i,
  input  board_pkg::reg_data_t       reg_wdata_i,
  output board_pkg::reg_data_t       reg_rdata_o,
  output logic                       reg_rvalid_o,
  // Board switches and indicators
  input  board_pkg::fan_level_t      fan_sw_i,
  input  board_pkg::boot_mode_t      boot_mode_i,
  output logic [`BOARD_LED_W-1:0]    led_o,
  output board_pkg::boot_mode_t      boot_mode_o,
  output logic                       fan_pwm_o,
  output logic                       rtc_clk_o,
  // Host SPI
  input  logic                       spih_sck_i,
  input  logic                       spih_sck_en_i,
  input  logic [`BOARD_SPI_CS_W-1:0] spih_csb_i,
  input  logic [`BOARD_SPI_CS_W-1:0] spih_csb_en_i,
  input  logic [`BOARD_QSPI_W-1:0]   spih_sd_i,
  input  logic [`BOARD_QSPI_W-1:0]   spih_sd_en_i,
  output logic [`BOARD_QSPI_W-1:0]   spih_sd_o_to_host,
  // SD card
  output logic                       sd_sclk_o,
  output logic                       sd_cs_o,
  output logic                       sd_cmd_o,
  input  logic                       sd_dat0_i,
  // Quad-SPI flash
  output logic                       qspi_sck_o,
  output logic                       qspi_sck_oe_o,
  output logic                       qspi_csb_o,
  output logic                       qspi_csb_oe_o,
  output logic [`BOARD_QSPI_W-1:0]   qspi_sd_o,
  output logic [`BOARD_QSPI_W-1:0]   qspi_sd_oe_o,
  input  logic [`BOARD_QSPI_W-1:0]   qspi_sd_i
);

  board_pkg::fan_level_t fan_level;

  rtc_divider i_rtc_divider (
    .soc_clk   ( soc_clk   ),
    .rst_n     ( rst_n     ),
    .rtc_clk_o ( rtc_clk_o )
  );

  board_cfg_regs i_board_cfg_regs (
    .soc_clk      ( soc_clk      ),
    .rst_n        ( rst_n        ),
    .reg_req_i    ( reg_req_i    ),
    .reg_we_i     ( reg_we_i     ),
    .reg_addr_i   ( reg_addr_i   ),
    .reg_wdata_i  ( reg_wdata_i  ),
    .fan_sw_i     ( fan_sw_i     ),
    .boot_mode_i  ( boot_mode_i  ),
    .reg_rdata_o  ( reg_rdata_o  ),
    .reg_rvalid_o ( reg_rvalid_o ),
    .led_o        ( led_o        ),
    .fan_level_o  ( fan_level    ),
    .boot_mode_o  ( boot_mode_o  )
  );

  fan_pwm i_fan_pwm (
    .soc_clk   ( soc_clk   ),
    .rst_n     ( rst_n     ),
    .level_i   ( fan_level ),
    .fan_pwm_o ( fan_pwm_o )
  );

  spi_pin_mux i_spi_pin_mux (
    .spih_sck_i        ( spih_sck_i        ),
    .spih_sck_en_i     ( spih_sck_en_i     ),
    .spih_csb_i        ( spih_csb_i        ),
    .spih_csb_en_i     ( spih_csb_en_i     ),
    .spih_sd_i         ( spih_sd_i         ),
    .spih_sd_en_i      ( spih_sd_en_i      ),
    .spih_sd_o_to_host ( spih_sd_o_to_host ),
    .sd_sclk_o         ( sd_sclk_o         ),
    .sd_cs_o           ( sd_cs_o           ),
    .sd_cmd_o          ( sd_cmd_o          ),
    .sd_dat0_i         ( sd_dat0_i         ),
    .qspi_sck_o        ( qspi_sck_o        ),
    .qspi_sck_oe_o     ( qspi_sck_oe_o     ),
    .qspi_csb_o        ( qspi_csb_o        ),
    .qspi_csb_oe_o     ( qspi_csb_oe_o     ),
    .qspi_sd_o         ( qspi_sd_o         ),
    .qspi_sd_oe_o      ( qspi_sd_oe_o      ),
    .qspi_sd_i         ( qspi_sd_i         )
  );

endmodule

// ==== tb/tb_clock_gen.sv ====
// Testbench clock and reset source: 20 ns soc_clk, rst_n low for 8 cycles

module tb_clock_gen (
  output logic soc_clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    soc_clk = 1'b0;
    forever #10 soc_clk = ~soc_clk;
  end

  // Release on a rising edge, like a synchronized board reset
  initial begin
    rst_n = 1'b0;
    repeat (8) @(posedge soc_clk);
    rst_n <= 1'b1;
  end

endmodule

// ==== tb/board_io_properties.sv ====
// Bound assertions: register read timing, fan output at level 0, flash enables

`include "board_params.svh"

module board_io_properties (
  input logic                       soc_clk,
  input logic                       rst_n,
  input logic                       reg_req_i,
  input logic                       reg_we_i,
  input logic                       reg_rvalid_o,
  input board_pkg::fan_level_t      fan_level,
  input logic                       fan_pwm_o,
  input logic                       spih_sck_en_i,
  input logic [`BOARD_SPI_CS_W-1:0] spih_csb_en_i,
  input logic [`BOARD_QSPI_W-1:0]   spih_sd_en_i,
  input logic                       qspi_sck_oe_o,
  input logic                       qspi_csb_oe_o,
  input logic [`BOARD_QSPI_W-1:0]   qspi_sd_oe_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // Read response only in the cycle after a read strobe
  rvalid_after_read: assert property (@(posedge soc_clk) disable iff (!rst_n)
    reg_rvalid_o |-> $past(reg_req_i & ~reg_we_i))
    else $error("reg_rvalid_o high without a read strobe one cycle earlier");

  read_gets_rvalid: assert property (@(posedge soc_clk) disable iff (!rst_n)
    (reg_req_i & ~reg_we_i) |=> reg_rvalid_o)
    else $error("read strobe not answered by reg_rvalid_o on the next cycle");

  fan_off_at_zero: assert property (@(posedge soc_clk) disable iff (!rst_n)
    (fan_level == '0) |-> !fan_pwm_o)
    else $error("fan_pwm_o high while the fan level is zero");

  // Flash pads take the host enables unchanged
  flash_oe_follow: assert property (@(posedge soc_clk) disable iff (!rst_n)
    (qspi_sck_oe_o == spih_sck_en_i) && (qspi_csb_oe_o == spih_csb_en_i[1])
    && (qspi_sd_oe_o == spih_sd_en_i))
    else $error("flash output enables differ from the host enables");

endmodule

// ==== tb/tb_board_io.sv ====
// Testbench top with stimulus, reference model, compare process, typed checks and summary

`include "board_params.svh"

module tb_board_io;
  timeunit 1ns;
  timeprecision 1ps;

  localparam board_pkg::reg_addr_t AddrLed  = board_pkg::reg_addr_t'(`BOARD_ADDR_LED);
  localparam board_pkg::reg_addr_t AddrCtrl = board_pkg::reg_addr_t'(`BOARD_ADDR_CTRL);
  localparam board_pkg::reg_addr_t AddrFree = 4'd9;

  logic soc_clk, rst_n;
  logic reg_req_i, reg_we_i, reg_rvalid_o;
  board_pkg::reg_addr_t reg_addr_i;
  board_pkg::reg_data_t reg_wdata_i, reg_rdata_o;
  board_pkg::fan_level_t fan_sw_i;
  board_pkg::boot_mode_t boot_mode_i, boot_mode_o;
  logic [`BOARD_LED_W-1:0] led_o;
  logic fan_pwm_o, rtc_clk_o;
  logic spih_sck_i, spih_sck_en_i;
  logic [`BOARD_SPI_CS_W-1:0] spih_csb_i, spih_csb_en_i;
  logic [`BOARD_QSPI_W-1:0] spih_sd_i, spih_sd_en_i, spih_sd_o_to_host;
  logic sd_sclk_o, sd_cs_o, sd_cmd_o, sd_dat0_i;
  logic qspi_sck_o, qspi_sck_oe_o, qspi_csb_o, qspi_csb_oe_o;
  logic [`BOARD_QSPI_W-1:0] qspi_sd_o, qspi_sd_oe_o, qspi_sd_i;

  // Model of the register contents and switches
  logic [`BOARD_LED_W-1:0] m_leds = '0;
  logic m_ovr = 1'b0;
  logic m_sel = 1'b0;
  logic [3:0] m_lvl = '0;
  logic [1:0] m_mode = '0;
  logic [3:0] m_sw = '0;

  logic [31:0] lcg_state = 32'd92;
  logic spi_chk = 1'b0;
  logic read_pending = 1'b0;
  int checks = 0;
  int errors = 0;
  int err_mark = 0;
  int reads_done = 0;
  string exp_names[$];
  board_pkg::reg_data_t exp_words[$];

  tb_clock_gen clk_gen (.soc_clk(soc_clk), .rst_n(rst_n));

  board_io_top uut (.*);

  bind board_io_top board_io_properties props (
    .soc_clk       ( soc_clk       ),
    .rst_n         ( rst_n         ),
    .reg_req_i     ( reg_req_i     ),
    .reg_we_i      ( reg_we_i      ),
    .reg_rvalid_o  ( reg_rvalid_o  ),
    .fan_level     ( fan_level     ),
    .fan_pwm_o     ( fan_pwm_o     ),
    .spih_sck_en_i ( spih_sck_en_i ),
    .spih_csb_en_i ( spih_csb_en_i ),
    .spih_sd_en_i  ( spih_sd_en_i  ),
    .qspi_sck_oe_o ( qspi_sck_oe_o ),
    .qspi_csb_oe_o ( qspi_csb_oe_o ),
    .qspi_sd_oe_o  ( qspi_sd_oe_o  )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and random source
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Register readback from the modelled contents
  function automatic board_pkg::reg_data_t expect_read(board_pkg::reg_addr_t addr);
    board_pkg::reg_data_t w;
    w = '0;
    if (addr == AddrLed) begin
      w[`BOARD_LED_W-1:0] = m_leds;
    end else if (addr == AddrCtrl) begin
      w[3:0] = m_ovr ? m_lvl : m_sw;
      w[4]   = m_ovr;
      w[6:5] = m_mode;
      w[7]   = m_sel;
    end
    return w;
  endfunction

  // SPI pins packed as sd, flash, then returned data from bit 0 upward
  function automatic board_pkg::reg_data_t expect_spi(
    logic sck, logic sck_en, logic [1:0] csb, logic [1:0] csb_en,
    logic [3:0] sd, logic [3:0] sd_en, logic dat0, logic [3:0] flash_in);
    board_pkg::reg_data_t w;
    logic [3:0] ret;
    ret = 4'b0000;
    if (!csb[0]) ret[1] = dat0;
    if (!csb[1]) ret = ret | flash_in;
    w = '0;
    w[0]     = sck_en ? sck : 1'b1;
    w[1]     = csb_en[0] ? csb[0] : 1'b1;
    w[2]     = sd_en[0] ? sd[0] : 1'b1;
    w[3]     = sck;
    w[4]     = sck_en;
    w[5]     = csb[1];
    w[6]     = csb_en[1];
    w[10:7]  = sd;
    w[14:11] = sd_en;
    w[18:15] = ret;
    return w;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Typed checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_word(input string name, input board_pkg::reg_data_t exp,
                            input board_pkg::reg_data_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_level(input string name, input board_pkg::fan_level_t exp,
                             input board_pkg::fan_level_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_boot(input string name, input board_pkg::boot_mode_t exp,
                            input board_pkg::boot_mode_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Mismatch %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Mismatch %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  // Compare process samples the outputs at each rising edge
  always @(posedge soc_clk) begin : compare
    board_pkg::reg_data_t spi_act;
    if (rst_n) begin
      check_bit("rvalid_timing", read_pending, reg_rvalid_o);
      if (reg_rvalid_o) begin
        if (exp_words.size() == 0) begin
          errors++;
          $display("Read data returned while no read was outstanding");
        end else begin
          check_word(exp_names.pop_front(), exp_words.pop_front(), reg_rdata_o);
        end
        reads_done++;
      end
      if (spi_chk) begin
        spi_act = {13'b0, spih_sd_o_to_host, qspi_sd_oe_o, qspi_sd_o, qspi_csb_oe_o,
                   qspi_csb_o, qspi_sck_oe_o, qspi_sck_o, sd_cmd_o, sd_cs_o, sd_sclk_o};
        check_word("spi_route", expect_spi(spih_sck_i, spih_sck_en_i, spih_csb_i,
                   spih_csb_en_i, spih_sd_i, spih_sd_en_i, sd_dat0_i, qspi_sd_i), spi_act);
      end
    end
    read_pending = rst_n & reg_req_i & ~reg_we_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Bus tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic reg_write(input board_pkg::reg_addr_t addr,
                           input board_pkg::reg_data_t data);
    reg_req_i   <= 1'b1;
    reg_we_i    <= 1'b1;
    reg_addr_i  <= addr;
    reg_wdata_i <= data;
    @(posedge soc_clk);
    reg_req_i   <= 1'b0;
    reg_we_i    <= 1'b0;
  endtask

  task automatic write_ctrl(input logic ovr, input logic [3:0] lvl,
                            input logic [1:0] mode, input logic sel);
    board_pkg::reg_data_t data;
    data      = '0;
    data[3:0] = lvl;
    data[4]   = ovr;
    data[6:5] = mode;
    data[7]   = sel;
    reg_write(AddrCtrl, data);
    m_ovr  = ovr;
    m_lvl  = lvl;
    m_mode = mode;
    m_sel  = sel;
  endtask

  task automatic reg_read(input string name, input board_pkg::reg_addr_t addr);
    int target;
    int n;
    target = reads_done + 1;
    exp_names.push_back(name);
    exp_words.push_back(expect_read(addr));
    reg_req_i  <= 1'b1;
    reg_we_i   <= 1'b0;
    reg_addr_i <= addr;
    @(posedge soc_clk);
    reg_req_i  <= 1'b0;
    n = 0;
    while (reads_done < target && n < 8) begin
      @(posedge soc_clk);
      n++;
    end
    if (reads_done < target) begin
      errors++;
      $display("Timeout: no read response for %s", name);
    end
  endtask

  task automatic rtc_toggle_gap(output int gap);
    logic prev;
    prev = rtc_clk_o;
    gap  = 0;
    while (rtc_clk_o === prev && gap < 60) begin
      @(posedge soc_clk);
      gap++;
    end
    if (rtc_clk_o === prev) begin
      errors++;
      $display("Timeout: rtc_clk_o did not toggle within 60 cycles");
    end
  endtask

  task automatic end_test(input string name);
    $display("Test %-10s done, %0d errors", name, errors - err_mark);
    err_mark = errors;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    int n;
    int gap;
    int cnt;
    int levels[5];
    logic [31:0] r;
    levels = '{0, 1, 7, 14, 15};
    reg_req_i = 1'b0;
    reg_we_i = 1'b0;
    reg_addr_i = '0;
    reg_wdata_i = '0;
    fan_sw_i = '0;
    boot_mode_i = '0;
    spih_sck_i = 1'b0;
    spih_sck_en_i = 1'b0;
    spih_csb_i = '1;
    spih_csb_en_i = '0;
    spih_sd_i = '0;
    spih_sd_en_i = '0;
    sd_dat0_i = 1'b0;
    qspi_sd_i = '0;
    n = 0;
    while (!rst_n && n < 40) begin
      @(posedge soc_clk);
      n++;
    end
    if (!rst_n) begin
      errors++;
      $display("Timeout: reset was never released");
    end
    @(posedge soc_clk);

    // RTC starts low and toggles every 25 cycles
    check_bit("rtc_reset", 1'b0, rtc_clk_o);
    rtc_toggle_gap(gap);
    repeat (2) begin
      rtc_toggle_gap(gap);
      check_word("rtc_half_period", 32'd25, gap);
    end
    end_test("rtc");

    for (int i = 0; i < 4; i++) begin
      r = lcg_next();
      reg_write(AddrLed, r);
      m_leds = r[`BOARD_LED_W-1:0];
      @(posedge soc_clk);
      check_word("led_out", board_pkg::reg_data_t'(m_leds), board_pkg::reg_data_t'(led_o));
      reg_read("led_read", AddrLed);
    end
    reg_write(AddrFree, lcg_next());
    reg_read("unmapped_read", AddrFree);
    reg_read("led_after_unmapped", AddrLed);
    reg_read("ctrl_after_unmapped", AddrCtrl);
    end_test("led");

    fan_sw_i <= 4'd5;
    m_sw = 4'd5;
    repeat (3) @(posedge soc_clk);
    reg_read("fan_follow_sw", AddrCtrl);
    write_ctrl(1'b1, 4'd9, 2'd0, 1'b0);
    fan_sw_i <= 4'd3;
    m_sw = 4'd3;
    repeat (3) @(posedge soc_clk);
    reg_read("fan_override_hold", AddrCtrl);
    write_ctrl(1'b0, 4'd0, 2'd0, 1'b0);
    fan_sw_i <= 4'd12;
    m_sw = 4'd12;
    repeat (3) @(posedge soc_clk);
    reg_read("fan_follow_again", AddrCtrl);
    end_test("fan_level");

    // One full PWM period per level
    foreach (levels[i]) begin
      write_ctrl(1'b1, 4'(levels[i]), 2'd0, 1'b0);
      repeat (3) @(posedge soc_clk);
      cnt = 0;
      repeat (`BOARD_FAN_STEPS) begin
        @(posedge soc_clk);
        if (fan_pwm_o) cnt++;
      end
      check_level($sformatf("pwm_duty_%0d", levels[i]), 4'(levels[i]), 4'(cnt));
    end
    end_test("pwm");

    write_ctrl(1'b0, 4'd0, 2'd0, 1'b0);
    boot_mode_i <= 2'd2;
    repeat (2) @(posedge soc_clk);
    check_boot("boot_from_pins", 2'd2, boot_mode_o);
    write_ctrl(1'b0, 4'd0, 2'd3, 1'b1);
    boot_mode_i <= 2'd1;
    repeat (2) @(posedge soc_clk);
    check_boot("boot_from_reg", 2'd3, boot_mode_o);
    reg_read("boot_ctrl_read", AddrCtrl);
    write_ctrl(1'b0, 4'd0, 2'd3, 1'b0);
    repeat (2) @(posedge soc_clk);
    check_boot("boot_back_to_pins", 2'd1, boot_mode_o);
    end_test("boot");

    for (int i = 0; i < 40; i++) begin
      r = lcg_next() >> 12;
      spih_sck_i    <= r[0];
      spih_sck_en_i <= r[1];
      spih_csb_i    <= r[3:2];
      spih_csb_en_i <= r[5:4];
      spih_sd_i     <= r[9:6];
      spih_sd_en_i  <= r[13:10];
      sd_dat0_i     <= r[14];
      qspi_sd_i     <= r[18:15];
      spi_chk       <= 1'b1;
      @(posedge soc_clk);
    end
    spi_chk <= 1'b0;
    @(posedge soc_clk);
    end_test("spi");

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+logic
logic/board_pkg.sv
logic/rtc_divider.sv
logic/board_cfg_regs.sv
logic/fan_pwm.sv
logic/spi_pin_mux.sv
logic/board_io_top.sv
tb/tb_clock_gen.sv
tb/board_io_properties.sv
tb/tb_board_io.sv
